/* src/pcs_defines.svh */
`ifndef PCS_DEFINES_SVH
`define PCS_DEFINES_SVH

// Number of store buffer slots, 4 and 16 also work
`define PCS_DEPTH 8

// Memory line geometry, one line is 32 bytes
`define PCS_LINE_BITS 256
`define PCS_LINE_BYTES 32

// Word select bits inside one line
`define PCS_LINE_WORD_BITS 3

`endif

/* src/pcs_pkg.sv */
package pcs_pkg;

    // Access size, straight from funct3[1:0]
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    // One store buffer slot
    typedef struct packed {
        logic        valid;
        logic [29:0] word_addr;
        logic [3:0]  wmask;
        logic [31:0] data;
    } pcs_entry_t;

endpackage

/* src/mem_op_decode.sv */
`timescale 1ns/1ps

module mem_op_decode (
    input  pcs_pkg::mem_size_t size,
    input  logic [31:0]        rs1,
    input  logic [31:0]        imm,
    input  logic [31:0]        rs2,
    output logic [29:0]        word_addr,
    output logic [3:0]         mask,
    output logic [31:0]        data
);

    logic [31:0] eff_addr;
    logic [3:0]  base_mask;
    logic [31:0] shifted;

    assign eff_addr  = rs1 + imm;
    assign word_addr = eff_addr[31:2];

    always_comb begin
        case (size)
            pcs_pkg::MEM_BYTE: base_mask = 4'b0001;
            pcs_pkg::MEM_HALF: base_mask = 4'b0011;
            pcs_pkg::MEM_WORD: base_mask = 4'b1111;
            default:           base_mask = 4'b0000;
        endcase
    end

    assign mask    = base_mask << eff_addr[1:0];
    assign shifted = rs2 << {eff_addr[1:0], 3'b000};

    // Lanes outside the mask are zeroed
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            data[8*j +: 8] = mask[j] ? shifted[8*j +: 8] : 8'h00;
        end
    end

endmodule

/* src/pcs_buffer.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module pcs_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              st_push,
    input  logic [29:0]                       st_word_addr,
    input  logic [3:0]                        st_wmask,
    input  logic [31:0]                       st_data,
    input  logic                              ld_valid,
    input  logic [29:0]                       ld_word_addr,
    input  logic [3:0]                        ld_rmask,
    input  logic                              vacate,
    output logic                              ld_hit,
    output logic [31:0]                       ld_data,
    output logic                              full,
    output logic                              empty,
    output logic [29-`PCS_LINE_WORD_BITS:0]   line_addr,
    output logic [`PCS_LINE_BITS-1:0]         line_data,
    output logic [`PCS_LINE_BYTES-1:0]        line_mask
);

    localparam int DEPTH      = `PCS_DEPTH;
    localparam int IDX_W      = $clog2(DEPTH);
    localparam int WSEL_W     = `PCS_LINE_WORD_BITS;
    localparam int LINE_BITS  = `PCS_LINE_BITS;
    localparam int LINE_BYTES = `PCS_LINE_BYTES;

    pcs_pkg::pcs_entry_t table_q [DEPTH];

    logic [DEPTH-1:0] valid_vec;
    logic [DEPTH-1:0] in_line;
    logic             merge_hit;
    logic [IDX_W-1:0] merge_idx;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] oldest_idx;
    logic             ld_match;
    logic [IDX_W-1:0] ld_idx;
    logic [WSEL_W-1:0] word_sel;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            valid_vec[i] = table_q[i].valid;
        end
    end

    assign full  = &valid_vec;
    assign empty = ~|valid_vec;

    // Lowest-index search, walking down so the lowest match wins
    always_comb begin
        merge_hit  = 1'b0;
        merge_idx  = '0;
        free_idx   = '0;
        oldest_idx = '0;
        ld_match   = 1'b0;
        ld_idx     = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (table_q[i].valid && table_q[i].word_addr == st_word_addr) begin
                merge_hit = 1'b1;
                merge_idx = IDX_W'(i);
            end
            if (!table_q[i].valid) begin
                free_idx = IDX_W'(i);
            end else begin
                oldest_idx = IDX_W'(i);
            end
            if (table_q[i].valid && table_q[i].word_addr == ld_word_addr &&
                table_q[i].wmask == ld_rmask) begin
                ld_match = 1'b1;
                ld_idx   = IDX_W'(i);
            end
        end
    end

    assign line_addr = table_q[oldest_idx].word_addr[29:WSEL_W];

    // Gather every valid slot in the oldest line
    always_comb begin
        line_data = '0;
        line_mask = '0;
        word_sel  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            in_line[i] = table_q[i].valid &&
                         table_q[i].word_addr[29:WSEL_W] == line_addr;
            if (in_line[i]) begin
                word_sel  = table_q[i].word_addr[WSEL_W-1:0];
                line_mask = line_mask | (LINE_BYTES'(table_q[i].wmask) << (4 * word_sel));
                line_data = line_data | (LINE_BITS'(table_q[i].data) << (32 * word_sel));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                table_q[i].valid <= 1'b0;
            end
        end else begin
            if (st_push) begin
                if (merge_hit) begin
                    // Byte merge into the existing word
                    for (int j = 0; j < 4; j++) begin
                        if (st_wmask[j]) begin
                            table_q[merge_idx].data[8*j +: 8] <= st_data[8*j +: 8];
                        end
                    end
                    table_q[merge_idx].wmask <= table_q[merge_idx].wmask | st_wmask;
                end else if (!full) begin
                    table_q[free_idx].valid     <= 1'b1;
                    table_q[free_idx].word_addr <= st_word_addr;
                    table_q[free_idx].wmask     <= st_wmask;
                    table_q[free_idx].data      <= st_data;
                end
            end
            if (vacate) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (in_line[i]) begin
                        table_q[i].valid <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_hit <= 1'b0;
        end else begin
            ld_hit <= ld_valid && ld_match;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid && ld_match) begin
            ld_data <= table_q[ld_idx].data;
        end
    end

endmodule

/* src/pcs_drain_ctrl.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module pcs_drain_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              full,
    input  logic                              empty,
    input  logic                              flush,
    input  logic [29-`PCS_LINE_WORD_BITS:0]   line_addr,
    input  logic [`PCS_LINE_BITS-1:0]         line_data,
    input  logic [`PCS_LINE_BYTES-1:0]        line_mask,
    input  logic                              mem_resp,
    output logic                              store_ready,
    output logic                              mem_req,
    output logic [29-`PCS_LINE_WORD_BITS:0]   mem_addr,
    output logic [`PCS_LINE_BITS-1:0]         mem_data,
    output logic [`PCS_LINE_BYTES-1:0]        mem_mask,
    output logic                              vacate
);

    typedef enum logic {
        S_IDLE,
        S_REQ
    } state_t;

    state_t state_q;
    logic   drain_q;
    logic   start_req;

    // Drain sticks until the table is empty and flush has dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            drain_q <= 1'b0;
        end else if (full || flush) begin
            drain_q <= 1'b1;
        end else if (empty) begin
            drain_q <= 1'b0;
        end
    end

    assign start_req = (state_q == S_IDLE) && drain_q && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE:  if (start_req) state_q <= S_REQ;
                S_REQ:   if (mem_resp) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Line snapshot held for the whole request
    always_ff @(posedge clk) begin
        if (start_req) begin
            mem_addr <= line_addr;
            mem_data <= line_data;
            mem_mask <= line_mask;
        end
    end

    assign mem_req = (state_q == S_REQ);
    assign vacate  = mem_req && mem_resp;

    // Table stays frozen while anything drains
    assign store_ready = !(full || drain_q || mem_req);

endmodule

/* src/pcs_top.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module pcs_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              st_valid,
    input  pcs_pkg::mem_size_t                st_size,
    input  logic [31:0]                       st_rs1,
    input  logic [31:0]                       st_imm,
    input  logic [31:0]                       st_rs2,
    output logic                              store_ready,
    input  logic                              ld_valid,
    input  pcs_pkg::mem_size_t                ld_size,
    input  logic [31:0]                       ld_rs1,
    input  logic [31:0]                       ld_imm,
    output logic                              ld_hit,
    output logic [31:0]                       ld_data,
    output logic                              mem_req,
    output logic [29-`PCS_LINE_WORD_BITS:0]   mem_addr,
    output logic [`PCS_LINE_BITS-1:0]         mem_data,
    output logic [`PCS_LINE_BYTES-1:0]        mem_mask,
    input  logic                              mem_resp,
    input  logic                              flush
);

    logic [29:0]                     st_word_addr;
    logic [3:0]                      st_wmask;
    logic [31:0]                     st_data;
    logic [29:0]                     ld_word_addr;
    logic [3:0]                      ld_rmask;
    logic                            full;
    logic                            empty;
    logic                            vacate;
    logic [29-`PCS_LINE_WORD_BITS:0] line_addr;
    logic [`PCS_LINE_BITS-1:0]       line_data;
    logic [`PCS_LINE_BYTES-1:0]      line_mask;

    mem_op_decode u_st_decode (
        .size      (st_size),
        .rs1       (st_rs1),
        .imm       (st_imm),
        .rs2       (st_rs2),
        .word_addr (st_word_addr),
        .mask      (st_wmask),
        .data      (st_data)
    );

    // Loads carry no data
    mem_op_decode u_ld_decode (
        .size      (ld_size),
        .rs1       (ld_rs1),
        .imm       (ld_imm),
        .rs2       (32'h0),
        .word_addr (ld_word_addr),
        .mask      (ld_rmask),
        .data      ()
    );

    pcs_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .st_push      (st_valid && store_ready),
        .st_word_addr (st_word_addr),
        .st_wmask     (st_wmask),
        .st_data      (st_data),
        .ld_valid     (ld_valid),
        .ld_word_addr (ld_word_addr),
        .ld_rmask     (ld_rmask),
        .vacate       (vacate),
        .ld_hit       (ld_hit),
        .ld_data      (ld_data),
        .full         (full),
        .empty        (empty),
        .line_addr    (line_addr),
        .line_data    (line_data),
        .line_mask    (line_mask)
    );

    pcs_drain_ctrl u_drain (
        .clk         (clk),
        .rst         (rst),
        .full        (full),
        .empty       (empty),
        .flush       (flush),
        .line_addr   (line_addr),
        .line_data   (line_data),
        .line_mask   (line_mask),
        .mem_resp    (mem_resp),
        .store_ready (store_ready),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_mask    (mem_mask),
        .vacate      (vacate)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held over four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* bench/pcs_checker.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module pcs_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            st_valid,
    input  pcs_pkg::mem_size_t              st_size,
    input  logic [31:0]                     st_rs1,
    input  logic [31:0]                     st_imm,
    input  logic [31:0]                     st_rs2,
    input  logic                            store_ready,
    input  logic                            ld_valid,
    input  pcs_pkg::mem_size_t              ld_size,
    input  logic [31:0]                     ld_rs1,
    input  logic [31:0]                     ld_imm,
    input  logic                            ld_hit,
    input  logic [31:0]                     ld_data,
    input  logic                            mem_req,
    input  logic [29-`PCS_LINE_WORD_BITS:0] mem_addr,
    input  logic [`PCS_LINE_BITS-1:0]       mem_data,
    input  logic [`PCS_LINE_BYTES-1:0]      mem_mask,
    input  logic                            mem_resp,
    input  logic                            flush,
    output int                              errors,
    output int                              checks
);

    localparam int DEPTH = `PCS_DEPTH;
    localparam int WB    = `PCS_LINE_WORD_BITS;

    logic                       m_valid [DEPTH];
    logic [29:0]                m_word  [DEPTH];
    logic [3:0]                 m_mask  [DEPTH];
    logic [31:0]                m_data  [DEPTH];
    logic                       m_drain;
    logic                       m_req;
    logic                       exp_hit;
    logic [31:0]                exp_data;
    logic [29-WB:0]             req_addr;
    logic [`PCS_LINE_BITS-1:0]  req_data;
    logic [`PCS_LINE_BYTES-1:0] req_mask;

    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic expect_value(input string what, input logic [255:0] got,
                                input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Address, byte lanes and shifted data of one aligned access
    function automatic void decode(input logic [1:0] size, input logic [31:0] ea,
                                   input logic [31:0] value, output logic [29:0] word,
                                   output logic [3:0] mask, output logic [31:0] lanes);
        int nbytes;
        int off;
        nbytes = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
        off    = int'(ea[1:0]);
        word   = ea[31:2];
        mask   = '0;
        lanes  = '0;
        for (int b = 0; b < nbytes; b++) begin
            mask[off + b]          = 1'b1;
            lanes[8 * (off + b) +: 8] = value[8 * b +: 8];
        end
    endfunction

    function automatic int slots_used();
        int n;
        n = 0;
        for (int i = 0; i < DEPTH; i++) begin
            if (m_valid[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // Line of the lowest valid slot with every valid word of that line
    task automatic oldest_line(output logic [29-WB:0] la,
                               output logic [`PCS_LINE_BITS-1:0] ld,
                               output logic [`PCS_LINE_BYTES-1:0] lm);
        int first;
        int w;
        first = -1;
        la    = '0;
        ld    = '0;
        lm    = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (m_valid[i]) begin
                first = i;
            end
        end
        if (first >= 0) begin
            la = m_word[first][29:WB];
            for (int i = 0; i < DEPTH; i++) begin
                if (m_valid[i] && m_word[i][29:WB] == la) begin
                    w               = int'(m_word[i][WB-1:0]);
                    ld[32 * w +: 32] = m_data[i];
                    lm[4 * w +: 4]   = m_mask[i];
                end
            end
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        m_drain = 1'b0;
        m_req   = 1'b0;
        exp_hit = 1'b0;
    endtask

    task automatic check_outputs();
        logic ready;
        ready = !(slots_used() == DEPTH || m_drain || m_req);
        expect_value("store_ready", 256'(store_ready), 256'(ready));
        expect_value("mem_req", 256'(mem_req), 256'(m_req));
        expect_value("ld_hit", 256'(ld_hit), 256'(exp_hit));
        if (exp_hit) begin
            expect_value("ld_data", 256'(ld_data), 256'(exp_data));
        end
        // Line taken when the request started, must hold until the response
        if (m_req && mem_req) begin
            expect_value("mem_addr", 256'(mem_addr), 256'(req_addr));
            expect_value("mem_data", 256'(mem_data), 256'(req_data));
            expect_value("mem_mask", 256'(mem_mask), 256'(req_mask));
        end
    endtask

    // Next model state, computed from the values before the rising edge
    task automatic apply_edge();
        logic [29:0]                wa;
        logic [3:0]                 mk;
        logic [31:0]                dt;
        logic [29-WB:0]             la;
        logic [`PCS_LINE_BITS-1:0]  ld;
        logic [`PCS_LINE_BYTES-1:0] lm;
        logic                       ready;
        int                         used;
        int                         slot;
        used    = slots_used();
        ready   = !(used == DEPTH || m_drain || m_req);
        exp_hit = 1'b0;
        if (ld_valid) begin
            decode(ld_size, ld_rs1 + ld_imm, 32'h0, wa, mk, dt);
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (m_valid[i] && m_word[i] == wa && m_mask[i] == mk) begin
                    exp_hit  = 1'b1;
                    exp_data = m_data[i];
                end
            end
        end
        if (m_req && mem_resp) begin
            oldest_line(la, ld, lm);
            for (int i = 0; i < DEPTH; i++) begin
                if (m_valid[i] && m_word[i][29:WB] == la) begin
                    m_valid[i] = 1'b0;
                end
            end
            m_req = 1'b0;
        end else if (m_drain && !m_req && used != 0) begin
            oldest_line(req_addr, req_data, req_mask);
            m_req = 1'b1;
        end
        if (used == DEPTH || flush) begin
            m_drain = 1'b1;
        end else if (used == 0) begin
            m_drain = 1'b0;
        end
        if (st_valid && ready) begin
            decode(st_size, st_rs1 + st_imm, st_rs2, wa, mk, dt);
            slot = -1;
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (m_valid[i] && m_word[i] == wa) begin
                    slot = i;
                end
            end
            if (slot >= 0) begin
                for (int b = 0; b < 4; b++) begin
                    if (mk[b]) begin
                        m_data[slot][8 * b +: 8] = dt[8 * b +: 8];
                    end
                end
                m_mask[slot] = m_mask[slot] | mk;
            end else begin
                for (int i = DEPTH - 1; i >= 0; i--) begin
                    if (!m_valid[i]) begin
                        slot = i;
                    end
                end
                m_valid[slot] = 1'b1;
                m_word[slot]  = wa;
                m_mask[slot]  = mk;
                m_data[slot]  = dt;
            end
        end
    endtask

    // Falling edge sees settled inputs and outputs
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            reset_model();
        end else begin
            check_outputs();
            apply_edge();
        end
    end

endmodule

/* bench/pcs_tb.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module pcs_tb;

    localparam int RANDOM_OPS   = 2000;
    localparam int DIRECTED_OPS = 80;
    localparam int MAX_CYCLES   = 50 * (RANDOM_OPS + DIRECTED_OPS) + 2000;

    logic                            clk;
    logic                            rst;
    logic                            st_valid;
    pcs_pkg::mem_size_t              st_size;
    logic [31:0]                     st_rs1;
    logic [31:0]                     st_imm;
    logic [31:0]                     st_rs2;
    logic                            store_ready;
    logic                            ld_valid;
    pcs_pkg::mem_size_t              ld_size;
    logic [31:0]                     ld_rs1;
    logic [31:0]                     ld_imm;
    logic                            ld_hit;
    logic [31:0]                     ld_data;
    logic                            mem_req;
    logic [29-`PCS_LINE_WORD_BITS:0] mem_addr;
    logic [`PCS_LINE_BITS-1:0]       mem_data;
    logic [`PCS_LINE_BYTES-1:0]      mem_mask;
    logic                            mem_resp;
    logic                            flush;
    int                              errors;
    int                              checks;
    int                              cycles = 0;
    int                              tests_run;
    int                              err_mark;
    int                              resp_wait;
    logic [31:0]                     rng;
    logic [31:0]                     lines [4];
    logic [31:0]                     saved [3];
    logic [31:0]                     a;
    logic [31:0]                     r;
    logic [1:0]                      sz;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    pcs_top u_pcs_top (
        .clk         (clk),
        .rst         (rst),
        .st_valid    (st_valid),
        .st_size     (st_size),
        .st_rs1      (st_rs1),
        .st_imm      (st_imm),
        .st_rs2      (st_rs2),
        .store_ready (store_ready),
        .ld_valid    (ld_valid),
        .ld_size     (ld_size),
        .ld_rs1      (ld_rs1),
        .ld_imm      (ld_imm),
        .ld_hit      (ld_hit),
        .ld_data     (ld_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_mask    (mem_mask),
        .mem_resp    (mem_resp),
        .flush       (flush)
    );

    pcs_checker u_check (
        .clk         (clk),
        .rst         (rst),
        .st_valid    (st_valid),
        .st_size     (st_size),
        .st_rs1      (st_rs1),
        .st_imm      (st_imm),
        .st_rs2      (st_rs2),
        .store_ready (store_ready),
        .ld_valid    (ld_valid),
        .ld_size     (ld_size),
        .ld_rs1      (ld_rs1),
        .ld_imm      (ld_imm),
        .ld_hit      (ld_hit),
        .ld_data     (ld_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_mask    (mem_mask),
        .mem_resp    (mem_resp),
        .flush       (flush),
        .errors      (errors),
        .checks      (checks)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Naturally aligned address inside one of the four pool lines
    function automatic logic [31:0] rand_addr(input logic [1:0] size);
        logic [31:0] v;
        v = rand32();
        case (size)
            2'd0:    return lines[v[1:0]] + 32'({v[4:2], v[6:5]});
            2'd1:    return lines[v[1:0]] + 32'({v[4:2], v[5], 1'b0});
            default: return lines[v[1:0]] + 32'({v[4:2], 2'b00});
        endcase
    endfunction

    // One clock step, the memory side answers here
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (mem_resp) begin
            mem_resp = 1'b0;
        end else if (mem_req) begin
            if (resp_wait == 0) begin
                resp_wait = 1 + int'(rand32() % 32'd5);
            end
            resp_wait--;
            if (resp_wait == 0) begin
                mem_resp = 1'b1;
            end
        end
    endtask

    task automatic store(input logic [1:0] size, input logic [31:0] addr,
                         input logic [31:0] data);
        while (!store_ready) begin
            next_cycle();
        end
        st_valid = 1'b1;
        st_size  = pcs_pkg::mem_size_t'(size);
        st_rs1   = rand32();
        st_imm   = addr - st_rs1;
        st_rs2   = data;
        next_cycle();
        st_valid = 1'b0;
    endtask

    task automatic load(input logic [1:0] size, input logic [31:0] addr);
        ld_valid = 1'b1;
        ld_size  = pcs_pkg::mem_size_t'(size);
        ld_rs1   = rand32();
        ld_imm   = addr - ld_rs1;
        next_cycle();
        ld_valid = 1'b0;
    endtask

    task automatic drain_all();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        while (!store_ready) begin
            next_cycle();
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        err_mark = errors;
        tests_run++;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        st_valid  = 1'b0;
        st_size   = pcs_pkg::MEM_WORD;
        st_rs1    = '0;
        st_imm    = '0;
        st_rs2    = '0;
        ld_valid  = 1'b0;
        ld_size   = pcs_pkg::MEM_WORD;
        ld_rs1    = '0;
        ld_imm    = '0;
        mem_resp  = 1'b0;
        flush     = 1'b0;
        resp_wait = 0;
        tests_run = 0;
        err_mark  = 0;
        rng       = 32'hc5452dc1;
        lines[0]  = 32'h0000_1000;
        lines[1]  = 32'h0000_1fe0;
        lines[2]  = 32'h8000_0040;
        lines[3]  = 32'h0003_a5a0;
        @(negedge rst);

        // Each size, then a load with another mask and one to the next word
        for (int k = 0; k < 6; k++) begin
            sz = 2'(k % 3);
            a  = lines[0] + 32'(4 * k);
            a  = a + ((sz == 2'd0) ? 32'(k % 4) : ((sz == 2'd1) ? 32'd2 : 32'd0));
            store(sz, a, rand32());
            load(sz, a);
            load((sz == 2'd2) ? 2'd0 : 2'd2, {a[31:2], 2'b00});
            load(sz, a + 32'd4);
        end
        drain_all();
        end_test(1, "store and load lanes");

        a = lines[1] + 32'd12;
        store(2'd0, a + 32'd1, rand32());
        load(2'd2, a);
        store(2'd1, a + 32'd2, rand32());
        load(2'd2, a);
        store(2'd0, a, rand32());
        load(2'd2, a);
        store(2'd0, a + 32'd3, rand32());
        load(2'd2, a);
        store(2'd0, a + 32'd1, rand32());
        load(2'd2, a);
        drain_all();
        end_test(2, "byte merge");

        for (int k = 0; k < `PCS_DEPTH; k++) begin
            store(2'd2, lines[k % 4] + 32'(4 * (k / 4)), rand32());
        end
        while (!store_ready) begin
            next_cycle();
        end
        end_test(3, "fill and drain");

        for (int k = 0; k < 2 * `PCS_DEPTH; k++) begin
            store(2'd2, rand_addr(2'd2), rand32());
        end
        drain_all();
        end_test(4, "slow memory");

        for (int k = 0; k < 3; k++) begin
            saved[k] = rand_addr(2'd2);
            store(2'd2, saved[k], rand32());
        end
        drain_all();
        for (int k = 0; k < 3; k++) begin
            load(2'd2, saved[k]);
        end
        end_test(5, "flush");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r  = rand32();
            sz = (r[9:8] == 2'd3) ? 2'd2 : r[9:8];
            if (r[3:0] < 4'd9) begin
                store(sz, rand_addr(sz), rand32());
            end else if (r[3:0] < 4'd15) begin
                load(sz, rand_addr(sz));
            end else begin
                flush = 1'b1;
                next_cycle();
                flush = 1'b0;
            end
        end
        drain_all();
        end_test(6, "random mix");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/pcs_pkg.sv
src/mem_op_decode.sv
src/pcs_buffer.sv
src/pcs_drain_ctrl.sv
src/pcs_top.sv
bench/tb_clock.sv
bench/pcs_checker.sv
bench/pcs_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module pcs_tb -f sim.f -o pcs_sim \
    && ./obj_dir/pcs_sim > sim.log
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
